// ==== tb.f ====
shift_pkg.sv
shift_if.sv
shift_issue_buffer.sv
shift_issue.sv
shift_execute.sv
reg_file.sv
shift_core.sv
tb_clock.sv
tb_shift_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_shift_core -f tb.f -o tb_shift_core
./obj_dir/tb_shift_core

// ==== tb_shift_core.sv ====
`timescale 1ns/1ns

module tb_shift_core;
	import shift_pkg::*;

	localparam int dp       = 4;
	localparam int timeout  = 200;
	localparam int n_random = 300;

	logic                 CLK;
	logic                 arst_n;
	logic                 dispatch_valid;
	logic                 dispatch_ready;
	shift_op_e            dispatch_op;
	reg_addr_t            dispatch_rd;
	reg_addr_t            dispatch_rs1;
	reg_addr_t            dispatch_rs2;
	logic [shamt_w-1:0]   dispatch_shamt;
	logic                 pre_en;
	reg_addr_t            pre_addr;
	logic [xlen-1:0]      pre_data;
	logic                 res_valid;
	reg_addr_t            res_rd;
	logic [xlen-1:0]      res_data;

	logic [63:0]  model_reg [32];    // Architectural state in program order
	logic [63:0]  expected [32];     // One write in flight per rd at most
	logic [63:0]  got_data [32];
	bit           outstanding [32];
	int           dispatch_count = 0;
	int           result_count = 0;
	int           stall_total = 0;

	tb_clock i_clock (.CLK(CLK));

	shift_core #(.dp(dp)) i_dut (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_op    (dispatch_op),
		.dispatch_rd    (dispatch_rd),
		.dispatch_rs1   (dispatch_rs1),
		.dispatch_rs2   (dispatch_rs2),
		.dispatch_shamt (dispatch_shamt),
		.pre_en         (pre_en),
		.pre_addr       (pre_addr),
		.pre_data       (pre_data),
		.res_valid      (res_valid),
		.res_rd         (res_rd),
		.res_data       (res_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Opcode order gives kind in [3:2], register form in [1], word form in [0]
	function automatic logic [63:0] model_shift(input shift_op_e op, input logic [63:0] a,
			input logic [63:0] b, input logic [5:0] imm);
		logic [3:0]   code;
		logic [5:0]   amt;
		logic [63:0]  v;
		logic [31:0]  w;
		int           n;
		code = op;
		amt  = code[1] ? b[5:0] : imm;
		n    = code[0] ? int'(amt[4:0]) : int'(amt);
		v    = a;
		w    = a[31:0];
		for (int k = 0; k < n; k++) begin    // One bit position per step
			case (code[3:2])
				2'd0: begin
					v = {v[62:0], 1'b0};
					w = {w[30:0], 1'b0};
				end
				2'd1: begin
					v = {1'b0, v[63:1]};
					w = {1'b0, w[31:1]};
				end
				default: begin
					v = {v[63], v[63:1]};
					w = {w[31], w[31:1]};
				end
			endcase
		end
		return code[0] ? {{32{w[31]}}, w} : v;
	endfunction

	function automatic logic [5:0] rand_amount();
		case ($urandom_range(5, 0))
			0:       return 6'd0;
			1:       return 6'd31;
			2:       return 6'd32;
			3:       return 6'd63;
			default: return 6'($urandom);
		endcase
	endfunction

	function automatic bit busy();
		for (int i = 0; i < 32; i++) begin
			if (outstanding[i]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] actual, input logic [63:0] exp_val);
		if (actual !== exp_val) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, exp_val);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic step();
		@(posedge CLK);
		#2;
	endtask

	// Every falling edge in flight goes through here, so no result is missed
	task automatic sample_negedge();
		@(negedge CLK);
		if (res_valid) begin
			if (!outstanding[res_rd]) begin
				fail_run("A result arrived for a register with no instruction in flight");
			end
			check("res_data", res_data, expected[res_rd]);
			outstanding[res_rd] = 1'b0;
			got_data[res_rd]    = res_data;
			result_count++;
		end
	endtask

	task automatic preload_reg(input reg_addr_t addr, input logic [63:0] data);
		pre_en          = 1'b1;
		pre_addr        = addr;
		pre_data        = data;
		model_reg[addr] = data;
		step();
		pre_en = 1'b0;
	endtask

	task automatic dispatch_instr(input shift_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2, input logic [5:0] shamt, input bit expect_stall);
		logic [63:0]  r;
		int           waited;
		waited         = 0;
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_rd    = rd;
		dispatch_rs1   = rs1;
		dispatch_rs2   = rs2;
		dispatch_shamt = shamt;
		sample_negedge();
		if (expect_stall) begin
			check("dispatch_ready", 64'(dispatch_ready), 64'd0);
		end
		while (!dispatch_ready) begin
			waited++;
			stall_total++;
			if (waited > timeout) begin
				fail_run("Timed out waiting for dispatch_ready");
			end
			sample_negedge();
		end
		r               = model_shift(op, model_reg[rs1], model_reg[rs2], shamt);
		expected[rd]    = r;
		outstanding[rd] = 1'b1;
		model_reg[rd]   = r;
		dispatch_count++;
		step();    // Transfer happens on this edge
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (busy()) begin
			waited++;
			if (waited > timeout) begin
				fail_run("Timed out waiting for outstanding results");
			end
			sample_negedge();
		end
		step();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [63:0]  v;
		logic [5:0]   amt;
		reg_addr_t    src1;
		reg_addr_t    src2;
		void'($urandom(63));
		arst_n         = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op    = slli;
		dispatch_rd    = '0;
		dispatch_rs1   = '0;
		dispatch_rs2   = '0;
		dispatch_shamt = '0;
		pre_en         = 1'b0;
		pre_addr       = '0;
		pre_data       = '0;
		for (int i = 0; i < 32; i++) begin
			model_reg[i] = '0;
			expected[i]  = '0;
			got_data[i]  = '0;
		end
		repeat (5) @(posedge CLK);
		#2;
		arst_n = 1'b1;

		sample_negedge();
		check("dispatch_ready", 64'(dispatch_ready), 64'd0);
		check("res_valid", 64'(res_valid), 64'd0);
		repeat (3) begin
			sample_negedge();
			check("dispatch_ready", 64'(dispatch_ready), 64'd1);
			check("res_valid", 64'(res_valid), 64'd0);
		end
		step();
		for (int i = 1; i < 32; i++) begin
			preload_reg(5'(i), {$urandom, $urandom});
		end

		// All twelve opcodes at the edge shift amounts
		for (int s = 0; s < 4; s++) begin
			amt = (s == 0) ? 6'd0 : (s == 1) ? 6'd31 : (s == 2) ? 6'd32 : 6'd63;
			v   = {$urandom, $urandom};
			v[5:0] = amt;    // Upper bits must be ignored
			preload_reg(5'd1, {$urandom, $urandom});
			preload_reg(5'd2, v);
			for (int k = 0; k < 12; k++) begin
				dispatch_instr(shift_op_e'(4'(k)), 5'(4 + k), 5'd1, 5'd2, amt, 1'b0);
			end
			wait_idle();
		end

		// Word forms and sign fill against known values
		preload_reg(5'd2, 64'h3f);
		preload_reg(5'd5, 64'h0000_0000_8000_00f0);
		preload_reg(5'd10, 64'h8000_0000_0000_0000);
		dispatch_instr(sraiw, 5'd6, 5'd5, 5'd0, 6'd4, 1'b0);
		dispatch_instr(srliw, 5'd7, 5'd5, 5'd0, 6'd4, 1'b0);
		dispatch_instr(slliw, 5'd8, 5'd5, 5'd0, 6'd1, 1'b0);
		dispatch_instr(slliw, 5'd9, 5'd5, 5'd0, 6'd0, 1'b0);
		dispatch_instr(srai, 5'd11, 5'd10, 5'd0, 6'd63, 1'b0);
		dispatch_instr(srli, 5'd12, 5'd10, 5'd0, 6'd63, 1'b0);
		dispatch_instr(sraw, 5'd13, 5'd5, 5'd2, 6'd0, 1'b0);
		wait_idle();
		check("sraiw x6", got_data[6], 64'hffff_ffff_f800_000f);
		check("srliw x7", got_data[7], 64'h0000_0000_0800_000f);
		check("slliw x8", got_data[8], 64'h0000_0000_0000_01e0);
		check("slliw x9", got_data[9], 64'hffff_ffff_8000_00f0);
		check("srai x11", got_data[11], 64'hffff_ffff_ffff_ffff);
		check("srli x12", got_data[12], 64'h0000_0000_0000_0001);
		check("sraw x13", got_data[13], 64'hffff_ffff_ffff_ffff);

		// Dependent chain fills the buffer, then independent ops overtake it
		stall_total = 0;
		for (int i = 0; i < 10; i++) begin
			src1 = (i == 0) ? 5'd1 : 5'(15 + i);
			src2 = (i == 0) ? 5'd2 : 5'(16 + $urandom_range(i - 1, 0));
			dispatch_instr(shift_op_e'(4'($urandom_range(11, 0))), 5'(16 + i), src1, src2,
				rand_amount(), 1'b0);
		end
		if (stall_total == 0) begin
			fail_run("dispatch_ready never dropped while the buffer was full");
		end
		for (int i = 0; i < 4; i++) begin
			dispatch_instr(shift_op_e'(4'($urandom_range(11, 0))), 5'(26 + i), 5'd3, 5'd4,
				rand_amount(), 1'b0);
		end
		wait_idle();

		// Second writer of a pending rd, then a writer of a register still to be read
		dispatch_instr(slli, 5'd20, 5'd1, 5'd0, 6'd3, 1'b0);
		dispatch_instr(slli, 5'd20, 5'd2, 5'd0, 6'd5, 1'b1);
		wait_idle();
		dispatch_instr(srli, 5'd21, 5'd1, 5'd0, 6'd1, 1'b0);
		dispatch_instr(srli, 5'd22, 5'd21, 5'd0, 6'd1, 1'b0);
		dispatch_instr(srli, 5'd23, 5'd22, 5'd0, 6'd1, 1'b0);
		dispatch_instr(sll, 5'd24, 5'd23, 5'd27, 6'd0, 1'b0);
		dispatch_instr(slli, 5'd27, 5'd2, 5'd0, 6'd2, 1'b1);
		wait_idle();

		for (int i = 0; i < n_random; i++) begin
			dispatch_instr(shift_op_e'(4'($urandom_range(11, 0))), 5'($urandom_range(31, 1)),
				5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)), rand_amount(), 1'b0);
		end
		wait_idle();
		check("result_count", 64'(result_count), 64'(dispatch_count));
		sample_negedge();
		check("dispatch_ready", 64'(dispatch_ready), 64'd1);

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever begin
			#20 CLK = ~CLK;    // 40 ns period
		end
	end

endmodule

// ==== shift_core.sv ====
`timescale 1ns/1ns

module shift_core #(
	parameter int dp = 4
) (
	input  logic                          CLK,
	input  logic                          arst_n,

	input  logic                          dispatch_valid,
	output logic                          dispatch_ready,
	input  shift_pkg::shift_op_e          dispatch_op,
	input  shift_pkg::reg_addr_t          dispatch_rd,
	input  shift_pkg::reg_addr_t          dispatch_rs1,
	input  shift_pkg::reg_addr_t          dispatch_rs2,
	input  logic [shift_pkg::shamt_w-1:0] dispatch_shamt,

	input  logic                          pre_en,
	input  shift_pkg::reg_addr_t          pre_addr,
	input  logic [shift_pkg::xlen-1:0]    pre_data,

	output logic                          res_valid,
	output shift_pkg::reg_addr_t          res_rd,
	output logic [shift_pkg::xlen-1:0]    res_data
);
	import shift_pkg::*;

	issue_entry_t dispatch_entry;

	issue_buf_if #(.dp(dp)) ibuf_bus ();
	exe_if                  exe_bus ();
	rf_if                   rf_bus ();

	assign dispatch_entry = '{op: dispatch_op, rd: dispatch_rd, rs1: dispatch_rs1,
	                          rs2: dispatch_rs2, shamt: dispatch_shamt};

	shift_issue_buffer #(.dp(dp)) i_buffer (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_entry (dispatch_entry),
		.ibuf           (ibuf_bus.producer),
		.rf             (rf_bus.dispatch)
	);

	shift_issue #(.dp(dp)) i_issue (
		.CLK    (CLK),
		.arst_n (arst_n),
		.ibuf   (ibuf_bus.consumer),
		.rf     (rf_bus.read),
		.exe    (exe_bus.source)
	);

	shift_execute i_execute (
		.CLK    (CLK),
		.arst_n (arst_n),
		.exe    (exe_bus.sink),
		.rf     (rf_bus.writeback)
	);

	reg_file i_reg_file (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.pre_en   (pre_en),
		.pre_addr (pre_addr),
		.pre_data (pre_data),
		.rf       (rf_bus.owner)
	);

	// Result port mirrors the writeback
	assign res_valid = rf_bus.wb_en;
	assign res_rd    = rf_bus.wb_rd;
	assign res_data  = rf_bus.wb_data;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic                          CLK,
	input  logic                          arst_n,

	input  logic                          pre_en,
	input  shift_pkg::reg_addr_t          pre_addr,
	input  logic [shift_pkg::xlen-1:0]    pre_data,

	rf_if.owner                           rf
);
	import shift_pkg::*;

	logic [xlen-1:0] mem [1:nreg-1];    // x0 has no storage

	always_comb begin
		rf.regs[0] = '0;
		for (int i = 1; i < nreg; i++) begin
			rf.regs[i] = mem[i];
		end
	end

	always_ff @(posedge CLK) begin
		if (rf.wb_en && (rf.wb_rd != '0)) begin
			mem[rf.wb_rd] <= rf.wb_data;
		end
		if (pre_en && (pre_addr != '0)) begin
			mem[pre_addr] <= pre_data;    // Only while the buffer is empty
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pending-write scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rf.pending <= '0;
		end else begin
			if (rf.wb_en) begin
				rf.pending[rf.wb_rd] <= 1'b0;
			end
			if (rf.set_pend) begin
				rf.pending[rf.pend_rd] <= 1'b1;
			end
		end
	end

	// Dispatch must hold off any second writer of a register
	a_set_pend_free: assert property (
		@(posedge CLK) disable iff (!arst_n)
		rf.set_pend |-> (rf.pend_rd != '0) && !rf.pending[rf.pend_rd]
	) else $error("set_pend on x%0d which is x0 or already pending", rf.pend_rd);

endmodule

// ==== shift_execute.sv ====
`timescale 1ns/1ns

module shift_execute (
	input  logic       CLK,
	input  logic       arst_n,

	exe_if.sink        exe,
	rf_if.writeback    rf
);
	import shift_pkg::*;

	logic [shamt_w-1:0]  amt;
	logic [31:0]         lo;
	logic [31:0]         res32;
	logic [xlen-1:0]     res64;
	logic [xlen-1:0]     result;

	always_comb begin
		amt = exe.packet.op2[shamt_w-1:0];    // W forms use amt[4:0]
		lo  = exe.packet.op1[31:0];
		if (exe.packet.fun[fun_sll]) begin
			res64 = exe.packet.op1 << amt;
			res32 = lo << amt[4:0];
		end else if (exe.packet.fun[fun_srl]) begin
			res64 = exe.packet.op1 >> amt;
			res32 = lo >> amt[4:0];
		end else begin
			res64 = $signed(exe.packet.op1) >>> amt;
			res32 = $signed(lo) >>> amt[4:0];
		end
		result = exe.packet.is32 ? {{32{res32[31]}}, res32} : res64;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rf.wb_en <= 1'b0;
		end else begin
			rf.wb_en <= exe.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe.valid) begin
			rf.wb_rd   <= exe.packet.rd;
			rf.wb_data <= result;
		end
	end

	a_fun_onehot: assert property (
		@(posedge CLK) disable iff (!arst_n)
		exe.valid |-> $onehot(exe.packet.fun)
	) else $error("fun not one-hot: %b", exe.packet.fun);

endmodule

// ==== shift_issue.sv ====
`timescale 1ns/1ns

module shift_issue #(
	parameter int dp = 4
) (
	input  logic           CLK,
	input  logic           arst_n,

	issue_buf_if.consumer  ibuf,
	rf_if.read             rf,
	exe_if.source          exe
);
	import shift_pkg::*;

	localparam int iw = $clog2(dp);

	logic [dp-1:0]  rs1_ok;
	logic [dp-1:0]  rs2_ok;
	logic [dp-1:0]  clear_raw;
	logic           any_ready;
	logic [iw-1:0]  pick;
	issue_entry_t   sel;
	exe_packet_t    pkt_next;

	// An entry's own rd counts as ready since it was not pending at dispatch
	// and no other writer of it can enter until this one writes back
	function automatic logic src_ready(reg_addr_t rs, reg_addr_t rd, logic [nreg-1:0] pend);
		return (rs == '0) | ~pend[rs] | (rs == rd);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// RAW readiness and pick
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < dp; i++) begin
			rs1_ok[i]    = src_ready(ibuf.entry[i].rs1, ibuf.entry[i].rd, rf.pending);
			rs2_ok[i]    = src_ready(ibuf.entry[i].rs2, ibuf.entry[i].rd, rf.pending);
			clear_raw[i] = ibuf.malloc[i] & rs1_ok[i] &
				(op_is_imm(ibuf.entry[i].op) | rs2_ok[i]);    // Immediate ops skip rs2
		end
	end

	always_comb begin
		any_ready = 1'b0;
		pick      = '0;
		for (int i = dp - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				any_ready = 1'b1;
				pick      = iw'(i);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operand build
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		sel           = ibuf.entry[pick];
		pkt_next.fun  = op_fun(sel.op);
		pkt_next.rd   = sel.rd;
		pkt_next.op1  = rf.regs[sel.rs1];
		pkt_next.op2  = op_is_imm(sel.op) ? {{(xlen-shamt_w){1'b0}}, sel.shamt}
		                                  : rf.regs[sel.rs2];
		pkt_next.is32 = op_is_word(sel.op);
	end

	assign ibuf.pop       = any_ready;    // Shifter never stalls
	assign ibuf.pop_index = pick;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			exe.valid <= 1'b0;
		end else begin
			exe.valid <= any_ready;
		end
	end

	always_ff @(posedge CLK) begin
		if (any_ready) begin
			exe.packet <= pkt_next;    // Hold when nothing is picked
		end
	end

	a_issued_pending: assert property (
		@(posedge CLK) disable iff (!arst_n)
		exe.valid && (exe.packet.rd != '0) |-> rf.pending[exe.packet.rd]
	) else $error("issued rd x%0d has no pending write", exe.packet.rd);

endmodule

// ==== shift_issue_buffer.sv ====
`timescale 1ns/1ns

module shift_issue_buffer #(
	parameter int dp = 4
) (
	input  logic                    CLK,
	input  logic                    arst_n,

	input  logic                    dispatch_valid,
	output logic                    dispatch_ready,
	input  shift_pkg::issue_entry_t dispatch_entry,

	issue_buf_if.producer           ibuf,
	rf_if.dispatch                  rf
);

	localparam int iw = $clog2(dp);

	logic           live_q;    // Low only in the first cycle after reset
	logic           full;
	logic [iw-1:0]  free_idx;
	logic           waw;
	logic           war;
	logic           hazard;
	logic           accept;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slot search and hazard stalls
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		full     = &ibuf.malloc;
		free_idx = '0;
		for (int i = dp - 1; i >= 0; i--) begin
			if (!ibuf.malloc[i]) begin
				free_idx = iw'(i);    // Lowest free slot wins
			end
		end
	end

	// Pending covers everything up to writeback, issue register included
	assign waw = rf.pending[dispatch_entry.rd];

	// A waiting reader of the new rd would see the younger value
	always_comb begin
		war = 1'b0;
		for (int i = 0; i < dp; i++) begin
			war = war | (ibuf.malloc[i] &
				((ibuf.entry[i].rs1 == dispatch_entry.rd) |
				 (ibuf.entry[i].rs2 == dispatch_entry.rd)));
		end
	end

	assign hazard         = (dispatch_entry.rd != '0) & (waw | war);    // x0 is never written
	assign dispatch_ready = live_q & ~full & ~hazard;
	assign accept         = dispatch_valid & dispatch_ready;

	assign rf.set_pend = accept & (dispatch_entry.rd != '0);
	assign rf.pend_rd  = dispatch_entry.rd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Occupancy and slot storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			live_q      <= 1'b0;
			ibuf.malloc <= '0;
		end else begin
			live_q <= 1'b1;
			if (ibuf.pop) begin
				ibuf.malloc[ibuf.pop_index] <= 1'b0;
			end
			// Popped slot is still marked, so the two never collide
			if (accept) begin
				ibuf.malloc[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			ibuf.entry[free_idx] <= dispatch_entry;
		end
	end

	a_pop_allocated: assert property (
		@(posedge CLK) disable iff (!arst_n)
		ibuf.pop |-> ibuf.malloc[ibuf.pop_index]
	) else $error("pop names a free slot %0d", ibuf.pop_index);

endmodule

// ==== shift_if.sv ====
`timescale 1ns/1ns

// Buffer slots as seen by the issue stage
interface issue_buf_if #(
	parameter int dp = 4
);
	import shift_pkg::*;

	logic [dp-1:0]          malloc;
	issue_entry_t           entry [dp];
	logic                   pop;
	logic [$clog2(dp)-1:0]  pop_index;

	modport producer (
		output malloc, entry,
		input  pop, pop_index
	);

	modport consumer (
		input  malloc, entry,
		output pop, pop_index
	);
endinterface

// Shifter is always ready, so no back-pressure
interface exe_if;
	import shift_pkg::*;

	logic         valid;
	exe_packet_t  packet;

	modport source (output valid, packet);
	modport sink   (input  valid, packet);
endinterface

interface rf_if;
	import shift_pkg::*;

	logic [xlen-1:0]  regs [nreg];
	logic [nreg-1:0]  pending;
	logic             wb_en;
	reg_addr_t        wb_rd;
	logic [xlen-1:0]  wb_data;
	logic             set_pend;
	reg_addr_t        pend_rd;

	modport owner (
		output regs, pending,
		input  wb_en, wb_rd, wb_data, set_pend, pend_rd
	);
	modport dispatch  (input pending, output set_pend, pend_rd);
	modport read      (input regs, pending);
	modport writeback (output wb_en, wb_rd, wb_data);
endinterface

// ==== shift_pkg.sv ====
package shift_pkg;

	localparam int xlen    = 64;
	localparam int nreg    = 32;
	localparam int shamt_w = 6;
	localparam int fun_w   = 3;

	// Bit positions in the one-hot fun field
	localparam int fun_sll = 2;
	localparam int fun_srl = 1;
	localparam int fun_sra = 0;

	typedef logic [4:0] reg_addr_t;

	typedef enum logic [3:0] {
		slli, slliw, sll, sllw,
		srli, srliw, srl, srlw,
		srai, sraiw, sra, sraw
	} shift_op_e;

	typedef struct packed {
		shift_op_e           op;
		reg_addr_t           rd;
		reg_addr_t           rs1;
		reg_addr_t           rs2;
		logic [shamt_w-1:0]  shamt;
	} issue_entry_t;

	typedef struct packed {
		logic [fun_w-1:0]  fun;
		reg_addr_t         rd;
		logic [xlen-1:0]   op1;
		logic [xlen-1:0]   op2;
		logic              is32;
	} exe_packet_t;

	function automatic logic op_is_imm(shift_op_e op);
		return op inside {slli, slliw, srli, srliw, srai, sraiw};
	endfunction

	function automatic logic op_is_word(shift_op_e op);
		return op inside {slliw, sllw, srliw, srlw, sraiw, sraw};
	endfunction

	function automatic logic [fun_w-1:0] op_fun(shift_op_e op);
		logic [fun_w-1:0] f;
		f = '0;
		case (op)
			slli, slliw, sll, sllw: f[fun_sll] = 1'b1;
			srli, srliw, srl, srlw: f[fun_srl] = 1'b1;
			default:                f[fun_sra] = 1'b1;
		endcase
		return f;
	endfunction

endpackage
